//--- Bender.yml
package:
  name: pim_conv

sources:
  - files:
      - verilog/pim_cfg_pkg.sv
      - verilog/pim_ctrl_pkg.sv
      - verilog/pim_feature_fifo.sv
      - verilog/pim_crossbar.sv
      - verilog/pim_recombine.sv
      - verilog/pim_conv_engine.sv
      - verilog/pim_conv_top.sv
  - target: test
    files:
      - dv/pim_conv_tb.sv
      - dv/pim_conv_chk.sv

//--- dv/pim_conv_chk.sv
// Protocol checker for input credits, output credits and weight writes
`default_nettype none

module pim_conv_chk #(
	parameter int FIFO_DEPTH  = 4,
	parameter int OUT_CREDITS = 2
) (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic in_credit,
	input logic out_valid,
	input logic out_credit,
	input logic w_we,
	input logic busy
);
	int snd_credits;
	int out_credits;
	int chk_errors = 0;

	// Shadow counts rebuilt from the handshakes
	always_ff @(posedge clk) begin
		if (!rst) begin
			snd_credits <= FIFO_DEPTH;
			out_credits <= OUT_CREDITS;
		end else begin
			snd_credits <= snd_credits - int'(in_valid) + int'(in_credit);
			out_credits <= out_credits - int'(out_valid) + int'(out_credit);
		end
	end

	a_in_credit: assert property (@(posedge clk) disable iff (!rst)
		in_valid |-> snd_credits > 0)
	else begin
		$error("in_valid while the sender holds no input credit");
		chk_errors++;
	end

	a_out_credit: assert property (@(posedge clk) disable iff (!rst)
		out_valid |-> out_credits > 0)
	else begin
		$error("out_valid while no output credit is left");
		chk_errors++;
	end

	a_weight_idle: assert property (@(posedge clk) disable iff (!rst)
		w_we |-> !busy)
	else begin
		$error("weight write while the engine is busy");
		chk_errors++;
	end

	// First cycle out of reset
	a_quiet_after_reset: assert property (@(posedge clk) $rose(rst) |-> !out_valid)
	else begin
		$error("out_valid high in the cycle after reset");
		chk_errors++;
	end

endmodule

bind pim_conv_top pim_conv_chk #(
	.FIFO_DEPTH(FIFO_DEPTH),
	.OUT_CREDITS(OUT_CREDITS)
) u_chk (
	.clk(clk), .rst(rst), .in_valid(in_valid), .in_credit(in_credit),
	.out_valid(out_valid), .out_credit(out_credit), .w_we(w_we), .busy(busy)
);

`default_nettype wire

//--- dv/pim_conv_tb.sv
// PIM convolution testbench, table-driven vectors against a bit-serial reference model
`default_nettype none

module pim_conv_tb
	import pim_cfg_pkg::*;
();
	localparam int CLIP_W = 6;
	localparam int ADC_MAX = (1 << CLIP_W) - 1;
	localparam int NUM_TESTS = 6;
	localparam int MAX_DELAY = 40;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * PIM_COLS * (HALF_W + 2 + MAX_DELAY) * 4;
	// Weight and vector fill modes
	localparam int M_RAND = 0;
	localparam int M_ONES = 1;
	localparam int M_ZERO = 2;
	localparam int M_MAX  = 3;

	logic clk = 1'b0;
	logic rst;
	logic in_valid;
	logic [PIM_N*IN_W-1:0] in_vec;
	logic in_credit;
	logic w_we;
	col_t w_col;
	logic [$clog2(PIM_N)-1:0] w_row;
	elem_t w_data;
	logic out_valid;
	col_t out_col;
	acc_t out_data;
	logic out_credit;
	logic busy;

	integer seed = 32'h78e3_742c;
	int errors = 0;
	int checks = 0;
	int cyc = 0;
	int sink_delay = 0;
	int in_credits = FIFO_DEPTH;
	int credit_pulses = 0;
	logic [IN_W-1:0] wt [PIM_COLS][PIM_N];
	logic [PIM_N*IN_W-1:0] vecs [$];
	col_t res_col [$];
	acc_t res_data [$];
	int credit_due [$];

	// Stimulus table
	string t_name [NUM_TESTS] = '{"zero_vec", "ones_wt", "random", "adc_clip",
		"backpressure", "fifo_burst"};
	int t_wmode [NUM_TESTS] = '{M_RAND, M_ONES, M_RAND, M_MAX, M_RAND, M_RAND};
	int t_vmode [NUM_TESTS] = '{M_ZERO, M_RAND, M_RAND, M_MAX, M_RAND, M_RAND};
	int t_delay [NUM_TESTS] = '{0, 0, 1, 0, MAX_DELAY, 2};
	int t_nvec  [NUM_TESTS] = '{1, 1, 2, 1, 2, FIFO_DEPTH};

	always #2 clk = ~clk;

	pim_conv_top #(.ADC_W(CLIP_W)) u_pim_conv_top (
		.clk(clk), .rst(rst), .in_valid(in_valid), .in_vec(in_vec), .in_credit(in_credit),
		.w_we(w_we), .w_col(w_col), .w_row(w_row), .w_data(w_data),
		.out_valid(out_valid), .out_col(out_col), .out_data(out_data),
		.out_credit(out_credit), .busy(busy)
	);

	// Result capture mid-cycle, each result owes the sink one credit
	always @(negedge clk) begin
		if (rst && out_valid) begin
			res_col.push_back(out_col);
			res_data.push_back(out_data);
			credit_due.push_back(cyc + 1 + sink_delay);
			assert (credit_due.size() <= OUT_CREDITS) else begin
				$display("More than %0d results outstanding without credit", OUT_CREDITS);
				errors++;
			end
		end
		if (rst && in_credit) begin
			credit_pulses++;
			in_credits++;
		end
	end

	// Sink hands back at most one credit per cycle once its delay is over
	always @(posedge clk) begin
		cyc++;
		#1;
		out_credit = 1'b0;
		if (credit_due.size() > 0 && credit_due[0] <= cyc) begin
			out_credit = 1'b1;
			void'(credit_due.pop_front());
		end
	end

	function automatic int adc_clip(input int sum);
		return (sum > ADC_MAX) ? ADC_MAX : sum;
	endfunction

	// Four clipped slice sums per input bit, placed by weight half and bit position
	function automatic acc_t model_dot(input int c, input logic [PIM_N*IN_W-1:0] v);
		acc_t sum;
		int hh;
		int hl;
		int lh;
		int ll;
		int term;
		logic [IN_W-1:0] e;
		sum = '0;
		for (int b = 0; b < HALF_W; b++) begin
			hh = 0;
			hl = 0;
			lh = 0;
			ll = 0;
			for (int r = 0; r < PIM_N; r++) begin
				e = v[r*IN_W +: IN_W];
				if (e[HALF_W + b]) begin
					hh += wt[c][r][IN_W-1:HALF_W];
					hl += wt[c][r][HALF_W-1:0];
				end
				if (e[b]) begin
					lh += wt[c][r][IN_W-1:HALF_W];
					ll += wt[c][r][HALF_W-1:0];
				end
			end
			term = (adc_clip(hh) << (2 * HALF_W)) + ((adc_clip(hl) + adc_clip(lh)) << HALF_W);
			term = term + adc_clip(ll);
			sum = sum + (acc_t'(term) << b);
		end
		return sum;
	endfunction

	function automatic logic [PIM_N*IN_W-1:0] make_vec(input int mode);
		logic [PIM_N*IN_W-1:0] v;
		for (int r = 0; r < PIM_N; r++) begin
			if (mode == M_ZERO)
				v[r*IN_W +: IN_W] = {IN_W{1'b0}};
			else if (mode == M_MAX)
				v[r*IN_W +: IN_W] = {IN_W{1'b1}};
			else
				v[r*IN_W +: IN_W] = IN_W'($random(seed));
		end
		return v;
	endfunction

	task automatic write_weights(input int mode);
		for (int c = 0; c < PIM_COLS; c++) begin
			for (int r = 0; r < PIM_N; r++) begin
				if (mode == M_ONES)
					wt[c][r] = IN_W'(1);
				else if (mode == M_MAX)
					wt[c][r] = {IN_W{1'b1}};
				else
					wt[c][r] = IN_W'($random(seed));
				w_we = 1'b1;
				w_col = col_t'(c);
				w_row = r[$clog2(PIM_N)-1:0];
				w_data = wt[c][r];
				@(posedge clk);
				#1;
			end
		end
		w_we = 1'b0;
	endtask

	// One vector under input credit
	task automatic push_vec(input logic [PIM_N*IN_W-1:0] v);
		while (in_credits == 0) begin
			@(posedge clk);
			#1;
		end
		in_valid = 1'b1;
		in_vec = v;
		in_credits--;
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	initial begin
		int t_err;
		acc_t exp_d;
		rst = 1'b0;
		in_valid = 1'b0;
		in_vec = '0;
		w_we = 1'b0;
		w_col = '0;
		w_row = '0;
		w_data = '0;
		out_credit = 1'b0;
		repeat (3) @(posedge clk);
		#1 rst = 1'b1;
		@(negedge clk);
		checks += 2;
		assert (!in_credit && !out_valid && !busy) else begin
			$display("in_credit, out_valid or busy high right after reset");
			errors++;
		end
		repeat (10) @(posedge clk);
		#1;
		assert (res_data.size() == 0) else begin
			$display("A result appeared although no vector was sent");
			errors++;
		end
		for (int t = 0; t < NUM_TESTS; t++) begin
			t_err = errors;
			sink_delay = t_delay[t];
			credit_pulses = 0;
			vecs.delete();
			res_col.delete();
			res_data.delete();
			write_weights(t_wmode[t]);
			for (int k = 0; k < t_nvec[t]; k++)
				vecs.push_back(make_vec(t_vmode[t]));
			foreach (vecs[k])
				push_vec(vecs[k]);
			while (res_data.size() < t_nvec[t] * PIM_COLS)
				@(posedge clk);
			while (busy || credit_due.size() > 0)
				@(posedge clk);
			#1;
			for (int k = 0; k < res_data.size(); k++) begin
				exp_d = model_dot(k % PIM_COLS, vecs[k / PIM_COLS]);
				checks += 2;
				assert (res_col[k] == col_t'(k % PIM_COLS)) else begin
					$display("FAIL %s out_col: expected %0d, actual %0d",
						t_name[t], k % PIM_COLS, res_col[k]);
					errors++;
				end
				assert (res_data[k] == exp_d) else begin
					$display("FAIL %s col %0d: expected %0d, actual %0d",
						t_name[t], k % PIM_COLS, exp_d, res_data[k]);
					errors++;
				end
			end
			checks++;
			assert (credit_pulses == t_nvec[t]) else begin
				$display("FAIL %s in_credit pulses: expected %0d, actual %0d",
					t_name[t], t_nvec[t], credit_pulses);
				errors++;
			end
			$display("Test %s: %0d results, %0d errors", t_name[t], res_data.size(),
				errors - t_err);
		end
		if (u_pim_conv_top.u_chk.chk_errors != 0)
			$display("Protocol checker flagged %0d violations", u_pim_conv_top.u_chk.chk_errors);
		errors += u_pim_conv_top.u_chk.chk_errors;
		$display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles, the DUT stopped producing results", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- pim_conv.f
verilog/pim_cfg_pkg.sv
verilog/pim_ctrl_pkg.sv
verilog/pim_feature_fifo.sv
verilog/pim_crossbar.sv
verilog/pim_recombine.sv
verilog/pim_conv_engine.sv
verilog/pim_conv_top.sv
dv/pim_conv_tb.sv
dv/pim_conv_chk.sv

//--- verilog/pim_cfg_pkg.sv
// PIM configuration package with default sizes and data width typedefs
`default_nettype none

package pim_cfg_pkg;

	// Default geometry, overridden through module parameters at the top level
	parameter int PIM_N       = 8;
	parameter int PIM_COLS    = 4;
	parameter int IN_W        = 8;
	parameter int HALF_W      = IN_W / 2;
	parameter int ADC_W       = 8;
	parameter int FIFO_DEPTH  = 4;
	parameter int OUT_CREDITS = 2;

	// One element or one full weight
	typedef logic [IN_W-1:0] elem_t;

	// One half of an element or weight
	typedef logic [HALF_W-1:0] half_t;

	// Column index
	typedef logic [$clog2(PIM_COLS)-1:0] col_t;

	// Clipped slice partial after the ADC
	typedef logic [ADC_W-1:0] adc_t;

	// Dot product result, wide enough for PIM_N full products
	typedef logic [23:0] acc_t;

endpackage

`default_nettype wire

//--- verilog/pim_conv_engine.sv
// Bit-serial convolution engine sequencing columns and bits, with output credits
`default_nettype none

module pim_conv_engine
	import pim_cfg_pkg::*;
	import pim_ctrl_pkg::*;
#(
	parameter int PIM_N       = pim_cfg_pkg::PIM_N,
	parameter int PIM_COLS    = pim_cfg_pkg::PIM_COLS,
	parameter int IN_W        = pim_cfg_pkg::IN_W,
	parameter int ADC_W       = pim_cfg_pkg::ADC_W,
	parameter int OUT_CREDITS = pim_cfg_pkg::OUT_CREDITS
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     fifo_valid,
	input  logic [PIM_N*IN_W-1:0]    fifo_vec,
	input  logic                     w_we,
	input  col_t                     w_col,
	input  logic [$clog2(PIM_N)-1:0] w_row,
	input  elem_t                    w_data,
	input  logic                     out_credit,
	output logic                     fifo_pop,
	output logic                     out_valid,
	output col_t                     out_col,
	output acc_t                     out_data,
	output logic                     busy
);
	localparam int HALF_W = IN_W / 2;
	localparam int BIT_W  = (HALF_W > 1) ? $clog2(HALF_W) : 1;
	localparam int CRD_W  = $clog2(OUT_CREDITS + 1);

	seq_state_t state;
	logic [PIM_N*IN_W-1:0] vec_q;
	logic [BIT_W-1:0] bit_cnt;
	logic [BIT_W-1:0] bit_q;
	col_t col_cnt;
	logic en;
	logic en_q;
	logic acc_clear;
	logic w_en;
	logic [PIM_N-1:0] bits_hi;
	logic [PIM_N-1:0] bits_lo;
	logic [CRD_W-1:0] credit;
	logic [ADC_W-1:0] p_hh;
	logic [ADC_W-1:0] p_hl;
	logic [ADC_W-1:0] p_lh;
	logic [ADC_W-1:0] p_ll;
	acc_t result;

	assign fifo_pop  = state == ST_LOAD;
	assign en        = state == ST_BITS;
	assign acc_clear = en && (bit_cnt == '0);
	assign busy      = state != ST_IDLE;
	assign out_valid = (state == ST_EMIT) && (credit != '0);
	assign out_col   = col_cnt;
	assign out_data  = result;
	// Weight writes only land while idle
	assign w_en      = w_we && !busy;

	// Current bit of every high and low half
	for (genvar i = 0; i < PIM_N; i++) begin : g_bits
		assign bits_hi[i] = vec_q[i*IN_W + HALF_W + bit_cnt];
		assign bits_lo[i] = vec_q[i*IN_W + bit_cnt];
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state   <= ST_IDLE;
			bit_cnt <= '0;
			col_cnt <= '0;
			en_q    <= 1'b0;
			credit  <= CRD_W'(OUT_CREDITS);
		end else begin
			en_q   <= en;
			credit <= credit - CRD_W'(out_valid) + CRD_W'(out_credit);
			case (state)
				ST_IDLE: begin
					if (fifo_valid)
						state <= ST_LOAD;
				end
				ST_LOAD: begin
					bit_cnt <= '0;
					col_cnt <= '0;
					state   <= ST_BITS;
				end
				ST_BITS: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == BIT_W'(HALF_W - 1))
						state <= ST_DRAIN;
				end
				// Last registered partial is added here
				ST_DRAIN: state <= ST_EMIT;
				ST_EMIT: begin
					if (out_valid) begin
						bit_cnt <= '0;
						if (col_cnt == col_t'(PIM_COLS - 1)) begin
							state <= ST_IDLE;
						end else begin
							col_cnt <= col_cnt + 1'b1;
							state   <= ST_BITS;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Vector latch and bit index aligned with the crossbar register
	always_ff @(posedge clk) begin
		if (state == ST_LOAD)
			vec_q <= fifo_vec;
		bit_q <= bit_cnt;
	end

	pim_crossbar #(.PIM_N(PIM_N), .PIM_COLS(PIM_COLS), .HALF_W(HALF_W), .ADC_W(ADC_W)) u_xbar_hh (
		.clk(clk), .w_we(w_en), .w_col(w_col), .w_row(w_row),
		.w_half(w_data[IN_W-1:HALF_W]), .en(en), .col(col_cnt), .bits(bits_hi), .partial(p_hh)
	);

	pim_crossbar #(.PIM_N(PIM_N), .PIM_COLS(PIM_COLS), .HALF_W(HALF_W), .ADC_W(ADC_W)) u_xbar_hl (
		.clk(clk), .w_we(w_en), .w_col(w_col), .w_row(w_row),
		.w_half(w_data[HALF_W-1:0]), .en(en), .col(col_cnt), .bits(bits_hi), .partial(p_hl)
	);

	pim_crossbar #(.PIM_N(PIM_N), .PIM_COLS(PIM_COLS), .HALF_W(HALF_W), .ADC_W(ADC_W)) u_xbar_lh (
		.clk(clk), .w_we(w_en), .w_col(w_col), .w_row(w_row),
		.w_half(w_data[IN_W-1:HALF_W]), .en(en), .col(col_cnt), .bits(bits_lo), .partial(p_lh)
	);

	pim_crossbar #(.PIM_N(PIM_N), .PIM_COLS(PIM_COLS), .HALF_W(HALF_W), .ADC_W(ADC_W)) u_xbar_ll (
		.clk(clk), .w_we(w_en), .w_col(w_col), .w_row(w_row),
		.w_half(w_data[HALF_W-1:0]), .en(en), .col(col_cnt), .bits(bits_lo), .partial(p_ll)
	);

	pim_recombine #(.HALF_W(HALF_W), .ADC_W(ADC_W)) u_recombine (
		.clk(clk), .rst(rst), .acc_clear(acc_clear), .acc_add(en_q), .bit_idx(bit_q),
		.p_hh(p_hh), .p_hl(p_hl), .p_lh(p_lh), .p_ll(p_ll), .result(result)
	);

endmodule

`default_nettype wire

//--- verilog/pim_conv_top.sv
// PIM convolution top level joining the feature FIFO and the bit-serial engine
`default_nettype none

module pim_conv_top
	import pim_cfg_pkg::*;
#(
	parameter int PIM_N       = pim_cfg_pkg::PIM_N,
	parameter int PIM_COLS    = pim_cfg_pkg::PIM_COLS,
	parameter int IN_W        = pim_cfg_pkg::IN_W,
	parameter int ADC_W       = pim_cfg_pkg::ADC_W,
	parameter int FIFO_DEPTH  = pim_cfg_pkg::FIFO_DEPTH,
	parameter int OUT_CREDITS = pim_cfg_pkg::OUT_CREDITS
) (
	input  logic                     clk,
	input  logic                     rst,
	// Input channel
	input  logic                     in_valid,
	input  logic [PIM_N*IN_W-1:0]    in_vec,
	output logic                     in_credit,
	// Weight write port
	input  logic                     w_we,
	input  col_t                     w_col,
	input  logic [$clog2(PIM_N)-1:0] w_row,
	input  elem_t                    w_data,
	// Output channel
	output logic                     out_valid,
	output col_t                     out_col,
	output acc_t                     out_data,
	input  logic                     out_credit,
	output logic                     busy
);
	logic fifo_valid;
	logic fifo_pop;
	logic [PIM_N*IN_W-1:0] fifo_vec;

	pim_feature_fifo #(.PIM_N(PIM_N), .IN_W(IN_W), .FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_vec(in_vec),
		.fifo_pop(fifo_pop),
		.fifo_valid(fifo_valid),
		.fifo_vec(fifo_vec),
		.in_credit(in_credit)
	);

	pim_conv_engine #(
		.PIM_N(PIM_N), .PIM_COLS(PIM_COLS), .IN_W(IN_W),
		.ADC_W(ADC_W), .OUT_CREDITS(OUT_CREDITS)
	) u_engine (
		.clk(clk), .rst(rst),
		.fifo_valid(fifo_valid), .fifo_vec(fifo_vec), .fifo_pop(fifo_pop),
		.w_we(w_we), .w_col(w_col), .w_row(w_row), .w_data(w_data),
		.out_credit(out_credit), .out_valid(out_valid), .out_col(out_col),
		.out_data(out_data), .busy(busy)
	);

endmodule

`default_nettype wire

//--- verilog/pim_crossbar.sv
// Crossbar slice holding one weight half per cell, with bit-line sum and ADC clip
`default_nettype none

module pim_crossbar
	import pim_cfg_pkg::*;
#(
	parameter int PIM_N    = pim_cfg_pkg::PIM_N,
	parameter int PIM_COLS = pim_cfg_pkg::PIM_COLS,
	parameter int HALF_W   = pim_cfg_pkg::HALF_W,
	parameter int ADC_W    = pim_cfg_pkg::ADC_W
) (
	input  logic                     clk,
	input  logic                     w_we,
	input  col_t                     w_col,
	input  logic [$clog2(PIM_N)-1:0] w_row,
	input  logic [HALF_W-1:0]        w_half,
	input  logic                     en,
	input  col_t                     col,
	input  logic [PIM_N-1:0]         bits,
	output logic [ADC_W-1:0]         partial
);
	// Sum of PIM_N halves, widened so the ADC limit always fits
	localparam int SUM_W = HALF_W + $clog2(PIM_N) + 1;
	localparam int CMP_W = (SUM_W > ADC_W) ? SUM_W : ADC_W;
	localparam logic [CMP_W-1:0] ADC_MAX = CMP_W'((1 << ADC_W) - 1);

	logic [HALF_W-1:0] mem [PIM_COLS][PIM_N];
	logic [CMP_W-1:0] col_sum;

	always_ff @(posedge clk) begin
		if (w_we)
			mem[w_col][w_row] <= w_half;
	end

	// Bit-line current: rows with an active input bit contribute their weight
	always_comb begin
		col_sum = '0;
		for (int r = 0; r < PIM_N; r++) begin
			if (bits[r])
				col_sum = col_sum + CMP_W'(mem[col][r]);
		end
	end

	// Saturating ADC
	always_ff @(posedge clk) begin
		if (en)
			partial <= (col_sum > ADC_MAX) ? ADC_W'(ADC_MAX) : ADC_W'(col_sum);
	end

endmodule

`default_nettype wire

//--- verilog/pim_ctrl_pkg.sv
// PIM control package with the sequencer states and slice weight shifts
`default_nettype none

package pim_ctrl_pkg;

	import pim_cfg_pkg::*;

	// Engine sequencer states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOAD,
		ST_BITS,
		ST_DRAIN,
		ST_EMIT
	} seq_state_t;

	// Weight position of each slice pair inside the full product
	parameter int SHIFT_HH  = 2 * HALF_W;
	parameter int SHIFT_MIX = HALF_W;
	parameter int SHIFT_LL  = 0;

endpackage

`default_nettype wire

//--- verilog/pim_feature_fifo.sv
// Feature vector FIFO, returns one input credit per consumed vector
`default_nettype none

module pim_feature_fifo
	import pim_cfg_pkg::*;
#(
	parameter int PIM_N      = pim_cfg_pkg::PIM_N,
	parameter int IN_W       = pim_cfg_pkg::IN_W,
	parameter int FIFO_DEPTH = pim_cfg_pkg::FIFO_DEPTH
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  in_valid,
	input  logic [PIM_N*IN_W-1:0] in_vec,
	input  logic                  fifo_pop,
	output logic                  fifo_valid,
	output logic [PIM_N*IN_W-1:0] fifo_vec,
	output logic                  in_credit
);
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [PIM_N*IN_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	// A push into a full FIFO is dropped, the sender broke the credit rule
	assign push       = in_valid && (count != CNT_W'(FIFO_DEPTH));
	assign pop        = fifo_pop && fifo_valid;
	assign fifo_valid = count != '0;
	assign fifo_vec   = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_vec;
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count     <= count + CNT_W'(push) - CNT_W'(pop);
			// Freed slot goes back to the sender one cycle later
			in_credit <= pop;
		end
	end

endmodule

`default_nettype wire

//--- verilog/pim_recombine.sv
// Shift-and-add recombiner merging the four slice partials into one dot product
`default_nettype none

module pim_recombine
	import pim_cfg_pkg::*;
	import pim_ctrl_pkg::*;
#(
	parameter int HALF_W = pim_cfg_pkg::HALF_W,
	parameter int ADC_W  = pim_cfg_pkg::ADC_W
) (
	input  logic                                        clk,
	input  logic                                        rst,
	input  logic                                        acc_clear,
	input  logic                                        acc_add,
	input  logic [((HALF_W > 1) ? $clog2(HALF_W) : 1)-1:0] bit_idx,
	input  logic [ADC_W-1:0]                            p_hh,
	input  logic [ADC_W-1:0]                            p_hl,
	input  logic [ADC_W-1:0]                            p_lh,
	input  logic [ADC_W-1:0]                            p_ll,
	output acc_t                                        result
);
	acc_t mix;
	acc_t bit_term;

	// Both mixed slices sit at the same weight position
	assign mix = acc_t'(p_hl) + acc_t'(p_lh);

	// Place each slice by weight half, then by input bit position
	assign bit_term = ((acc_t'(p_hh) << SHIFT_HH)
		+ (mix << SHIFT_MIX)
		+ (acc_t'(p_ll) << SHIFT_LL)) << bit_idx;

	always_ff @(posedge clk) begin
		if (!rst) begin
			result <= '0;
		end else if (acc_clear) begin
			result <= '0;
		end else if (acc_add) begin
			result <= result + bit_term;
		end
	end

endmodule

`default_nettype wire
